// File: source/pktGenPkg.sv
package pktGenPkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int DescAddrWidth = 8;
  localparam int NumDesc = 1 << DescAddrWidth;
  localparam int WbAddrWidth = 10;
  localparam int WbDataWidth = 16;

  // First word of the control space (address bit 9 set)
  localparam logic [WbAddrWidth-1:0] CtrlAddr = {1'b1, {(WbAddrWidth-1){1'b0}}};

  // Sequencer states
  localparam logic [2:0] SeqIdle = 3'd0;
  localparam logic [2:0] SeqFetch = 3'd1;
  localparam logic [2:0] SeqWait = 3'd2;
  localparam logic [2:0] SeqDecode = 3'd3;
  localparam logic [2:0] SeqEmit = 3'd4;

  // ------------------------------
  // Descriptor word, fill or end
  // ------------------------------
  typedef union packed {
    struct packed {
      logic       kind;
      logic [6:0] reserved;
      logic [7:0] length;
      logic [7:0] incr;
      logic [7:0] start;
    } fill;
    struct packed {
      logic        kind;
      logic [30:0] unused;
    } stop;
  } descWord_t;

endpackage

// File: source/wbHostPort.sv
module wbHostPort (
  input  logic                               clk_i,
  input  logic                               rstN_i,
  // Wishbone slave
  input  logic                               stb_i,
  input  logic                               cyc_i,
  input  logic                               we_i,
  input  logic [pktGenPkg::WbAddrWidth-1:0]  adr_i,
  input  logic [pktGenPkg::WbDataWidth-1:0]  dat_i,
  output logic [pktGenPkg::WbDataWidth-1:0]  dat_o,
  output logic                               ack_o,
  // Descriptor memory host port
  output logic                               memEn_o,
  output logic                               memWe_o,
  output logic [pktGenPkg::DescAddrWidth:0]  memAddr_o,
  output logic [pktGenPkg::WbDataWidth-1:0]  memWrData_o,
  input  logic [pktGenPkg::WbDataWidth-1:0]  memRdData_i,
  // Status and control
  input  logic                               busy_i,
  input  logic [7:0]                         pktCount_i,
  output logic                               startStrobe_o
);
  import pktGenPkg::*;

  logic                   wbAccess;
  logic                   accessDly;
  logic                   firstCycle;
  logic                   ctrlSpace;
  logic                   ctrlHit;
  logic                   rdFromMem;
  logic [WbDataWidth-1:0] ctrlRdData;

  // Only the first cycle of a held strobe counts as an access
  assign wbAccess = stb_i & cyc_i;
  assign firstCycle = wbAccess & ~accessDly;

  assign ctrlSpace = adr_i[WbAddrWidth-1];
  assign ctrlHit = (adr_i == CtrlAddr);

  // ------------------------------
  // Handshake and control register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      accessDly <= 1'b0;
      ack_o <= 1'b0;
      startStrobe_o <= 1'b0;
      rdFromMem <= 1'b0;
    end
    else
    begin
      accessDly <= wbAccess;
      ack_o <= firstCycle;
      startStrobe_o <= firstCycle & we_i & ctrlHit & dat_i[0];
      if (firstCycle)
        rdFromMem <= ~ctrlSpace;
    end
  end

  // Status snapshot, other control addresses read as zero
  always_ff @(posedge clk_i)
  begin
    if (firstCycle)
      ctrlRdData <= ctrlHit ? {pktCount_i, {(WbDataWidth-9){1'b0}}, busy_i} : '0;
  end

  // Memory access goes out in the first cycle, data returns with ack
  assign memEn_o = firstCycle & ~ctrlSpace;
  assign memWe_o = we_i;
  assign memAddr_o = adr_i[DescAddrWidth:0];
  assign memWrData_o = dat_i;

  assign dat_o = rdFromMem ? memRdData_i : ctrlRdData;

endmodule

// File: source/descMemory.sv
module descMemory (
  input  logic                                clk_i,
  // Host side, one 16-bit half per access
  input  logic                                hostEn_i,
  input  logic                                hostWe_i,
  input  logic [pktGenPkg::DescAddrWidth:0]   hostAddr_i,
  input  logic [pktGenPkg::WbDataWidth-1:0]   hostWrData_i,
  output logic [pktGenPkg::WbDataWidth-1:0]   hostRdData_o,
  // Sequencer side, whole descriptor
  input  logic                                descRd_i,
  input  logic [pktGenPkg::DescAddrWidth-1:0] descAddr_i,
  output logic [31:0]                         descData_o
);
  import pktGenPkg::*;

  // Each entry holds {high half, low half}
  logic [1:0][WbDataWidth-1:0] memArr [NumDesc];

  logic [DescAddrWidth-1:0] hostIdx;
  logic                     hostHalf;

  // Bit 0 picks the half, odd address is the high half
  assign hostIdx = hostAddr_i[DescAddrWidth:1];
  assign hostHalf = hostAddr_i[0];

  // ------------------------------
  // Host port
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (hostEn_i)
    begin
      if (hostWe_i)
        memArr[hostIdx][hostHalf] <= hostWrData_i;
      else
        hostRdData_o <= memArr[hostIdx][hostHalf];
    end
  end

  // ------------------------------
  // Descriptor read port
  // ------------------------------
  // Data one clock after the strobe, held until the next strobe
  always_ff @(posedge clk_i)
  begin
    if (descRd_i)
      descData_o <= memArr[descAddr_i];
  end

endmodule

// File: source/pktSequencer.sv
module pktSequencer (
  input  logic                                clk_i,
  input  logic                                rstN_i,
  input  logic                                start_i,
  // Descriptor read port
  output logic                                descRd_o,
  output logic [pktGenPkg::DescAddrWidth-1:0] descAddr_o,
  input  pktGenPkg::descWord_t                descData_i,
  output logic                                busy_o,
  // Byte stream
  output logic                                byteValid_o,
  output logic [7:0]                          byteData_o,
  output logic                                firstByte_o,
  output logic                                lastByte_o
);
  import pktGenPkg::*;

  logic [2:0]               state;
  logic [2:0]               stateNext;
  logic [DescAddrWidth-1:0] descIdx;
  descWord_t                desc;
  logic [7:0]               remaining;
  logic [7:0]               curByte;
  logic                     lastIndex;
  logic                     emitDone;

  assign lastIndex = (descIdx == '1);
  assign emitDone = (remaining == 8'd1);

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge clk_i or negedge rstN_i)
  begin
    if (!rstN_i)
      state <= SeqIdle;
    else
      state <= stateNext;
  end

  always_comb
  begin
    stateNext = state;
    case (state)
      SeqIdle:
        if (start_i)
          stateNext = SeqFetch;
      SeqFetch:
        stateNext = SeqWait;
      SeqWait:
        stateNext = SeqDecode;
      SeqDecode:
        if (desc.stop.kind)
          stateNext = SeqIdle;
        else if (desc.fill.length != 8'd0)
          stateNext = SeqEmit;
        else
          stateNext = lastIndex ? SeqIdle : SeqFetch;
      SeqEmit:
        if (emitDone)
          stateNext = lastIndex ? SeqIdle : SeqFetch;
      default:
        stateNext = SeqIdle;
    endcase
  end

  // ------------------------------
  // Index, descriptor and pattern
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (state == SeqIdle)
      descIdx <= '0;
    else if (stateNext == SeqFetch)
      descIdx <= descIdx + 1'b1;

    // Latch the descriptor when it arrives from memory
    if (state == SeqWait)
      desc <= descData_i;

    if (state == SeqDecode)
    begin
      remaining <= desc.fill.length;
      curByte <= desc.fill.start;
    end
    else if (state == SeqEmit)
    begin
      remaining <= remaining - 1'b1;
      curByte <= curByte + desc.fill.incr;   // wraps modulo 256
    end
  end

  assign descRd_o = (state == SeqFetch);
  assign descAddr_o = descIdx;
  assign busy_o = (state != SeqIdle);

  assign byteValid_o = (state == SeqEmit);
  assign byteData_o = curByte;
  assign firstByte_o = (state == SeqEmit) && (remaining == desc.fill.length);
  assign lastByte_o = (state == SeqEmit) && emitDone;

endmodule

// File: source/txFramer.sv
module txFramer (
  input  logic       clk_i,
  input  logic       rstN_i,
  input  logic       start_i,
  input  logic       byteValid_i,
  input  logic [7:0] byteData_i,
  input  logic       firstByte_i,
  input  logic       lastByte_i,
  output logic       txValid_o,
  output logic [7:0] txData_o,
  output logic       txSop_o,
  output logic       txEop_o,
  output logic [7:0] pktCount_o
);

  // Strobes and packet counter
  always_ff @(posedge clk_i or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      txValid_o <= 1'b0;
      txSop_o <= 1'b0;
      txEop_o <= 1'b0;
      pktCount_o <= 8'd0;
    end
    else
    begin
      txValid_o <= byteValid_i;
      txSop_o <= byteValid_i & firstByte_i;
      txEop_o <= byteValid_i & lastByte_i;
      if (start_i)
        pktCount_o <= 8'd0;
      else if (byteValid_i & lastByte_i)
        pktCount_o <= pktCount_o + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    txData_o <= byteData_i;
  end

endmodule

// File: source/pktGenTop.sv
module pktGenTop (
  input  logic                              clk_i,
  input  logic                              rstN_i,
  // Wishbone slave
  input  logic                              stb_i,
  input  logic                              cyc_i,
  input  logic                              we_i,
  input  logic [pktGenPkg::WbAddrWidth-1:0] adr_i,
  input  logic [pktGenPkg::WbDataWidth-1:0] dat_i,
  output logic [pktGenPkg::WbDataWidth-1:0] dat_o,
  output logic                              ack_o,
  // Byte stream out
  output logic                              txValid_o,
  output logic [7:0]                        txData_o,
  output logic                              txSop_o,
  output logic                              txEop_o
);
  import pktGenPkg::*;

  logic                     memEn;
  logic                     memWe;
  logic [DescAddrWidth:0]   memAddr;
  logic [WbDataWidth-1:0]   memWrData;
  logic [WbDataWidth-1:0]   memRdData;
  logic                     startStrobe;
  logic                     runStart;
  logic                     busy;
  logic [7:0]               pktCount;
  logic                     descRd;
  logic [DescAddrWidth-1:0] descAddr;
  descWord_t                descData;
  logic                     byteValid;
  logic [7:0]               byteData;
  logic                     firstByte;
  logic                     lastByte;

  // A start while busy neither restarts nor clears the count
  assign runStart = startStrobe & ~busy;

  wbHostPort hostPort (
    .clk_i        (clk_i),
    .rstN_i       (rstN_i),
    .stb_i        (stb_i),
    .cyc_i        (cyc_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .dat_o        (dat_o),
    .ack_o        (ack_o),
    .memEn_o      (memEn),
    .memWe_o      (memWe),
    .memAddr_o    (memAddr),
    .memWrData_o  (memWrData),
    .memRdData_i  (memRdData),
    .busy_i       (busy),
    .pktCount_i   (pktCount),
    .startStrobe_o(startStrobe)
  );

  descMemory descMem (
    .clk_i       (clk_i),
    .hostEn_i    (memEn),
    .hostWe_i    (memWe),
    .hostAddr_i  (memAddr),
    .hostWrData_i(memWrData),
    .hostRdData_o(memRdData),
    .descRd_i    (descRd),
    .descAddr_i  (descAddr),
    .descData_o  (descData)
  );

  pktSequencer sequencer (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .start_i    (runStart),
    .descRd_o   (descRd),
    .descAddr_o (descAddr),
    .descData_i (descData),
    .busy_o     (busy),
    .byteValid_o(byteValid),
    .byteData_o (byteData),
    .firstByte_o(firstByte),
    .lastByte_o (lastByte)
  );

  txFramer framer (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .start_i    (runStart),
    .byteValid_i(byteValid),
    .byteData_i (byteData),
    .firstByte_i(firstByte),
    .lastByte_i (lastByte),
    .txValid_o  (txValid_o),
    .txData_o   (txData_o),
    .txSop_o    (txSop_o),
    .txEop_o    (txEop_o),
    .pktCount_o (pktCount)
  );

endmodule

// File: testbench/pktGenModel.svh
`ifndef PKT_GEN_MODEL_SVH
`define PKT_GEN_MODEL_SVH

// Host copy of the descriptor table, kept in step with every write
logic [31:0] tableWords [NumDesc];

// Expected tx stream, one entry per byte as {sop, eop, data}
logic [9:0] expStream [$];
int         expPkts;

function automatic descWord_t makeFill(input logic [7:0] len, input logic [7:0] incr,
                                       input logic [7:0] start);
  descWord_t d;
  d.fill.kind = 1'b0;
  d.fill.reserved = 7'($urandom);
  d.fill.length = len;
  d.fill.incr = incr;
  d.fill.start = start;
  return d;
endfunction

function automatic descWord_t makeEnd();
  descWord_t d;
  d.stop.unused = 31'($urandom);
  d.stop.kind = 1'b1;
  return d;
endfunction

// Walk the table from index 0 the way a run does
function automatic void buildExpected();
  descWord_t  d;
  int         len;
  logic [7:0] b;
  expStream.delete();
  expPkts = 0;
  for (int i = 0; i < NumDesc; i++)
  begin
    d = tableWords[i];
    if (d.stop.kind)
      break;
    len = int'(d.fill.length);
    // Zero length gives no bytes and no packet
    for (int k = 0; k < len; k++)
    begin
      b = d.fill.start + 8'(k) * d.fill.incr;
      expStream.push_back({k == 0, k == len - 1, b});
    end
    if (len > 0)
      expPkts++;
  end
endfunction

`endif

// File: testbench/pktGenTb.sv
module pktGenTb;
  import pktGenPkg::*;

  localparam int ClkPeriod = 8;
  localparam int ResetCycles = 4;
  // Watchdog cost estimates in clock cycles
  localparam int AccessCost = 4;
  localparam int DescCost = 6;
  localparam int RunSlack = 40;

  logic                   clk;
  logic                   rstN;
  logic                   stb;
  logic                   cyc;
  logic                   we;
  logic [WbAddrWidth-1:0] adr;
  logic [WbDataWidth-1:0] datIn;
  logic [WbDataWidth-1:0] datOut;
  logic                   ack;
  logic                   txValid;
  logic [7:0]             txData;
  logic                   txSop;
  logic                   txEop;

  int         errorCount = 0;
  int         checkCount = 0;
  int         testCount = 0;
  int         testErrorBase = 0;
  int         cycleCount;
  int         cycleLimit = ResetCycles + RunSlack;
  logic [9:0] gotStream [$];
  int         gotPkts = 0;

  `include "pktGenModel.svh"

  pktGenTop UUT (
    .clk_i    (clk),
    .rstN_i   (rstN),
    .stb_i    (stb),
    .cyc_i    (cyc),
    .we_i     (we),
    .adr_i    (adr),
    .dat_i    (datIn),
    .dat_o    (datOut),
    .ack_o    (ack),
    .txValid_o(txValid),
    .txData_o (txData),
    .txSop_o  (txSop),
    .txEop_o  (txEop)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(ClkPeriod / 2) clk = ~clk;
  end

  // Collect tx bytes at the falling edge where outputs are stable
  always @(negedge clk)
  begin
    if (txValid)
    begin
      gotStream.push_back({txSop, txEop, txData});
      if (txEop)
        gotPkts++;
    end
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount <= cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout, the run did not finish within %0d cycles", cycleLimit);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------
  // Checking and bookkeeping
  // ------------------------------
  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("test %0d %s: %0d errors", testCount, name, errorCount - testErrorBase);
    testErrorBase = errorCount;
  endtask

  task automatic addBudget(input int accesses, input int descs, input int bytes);
    cycleLimit += accesses * AccessCost + descs * DescCost + bytes + RunSlack;
  endtask

  // ------------------------------
  // Wishbone master
  // ------------------------------
  task automatic wbAccess(input logic write, input logic [WbAddrWidth-1:0] addr,
                          input logic [15:0] wdata, output logic [15:0] rdata);
    int waitCycles;
    waitCycles = 0;
    @(negedge clk);
    // Previous ack must have been a single pulse
    checkValue("ack_o idle", 32'(ack), 32'd0);
    stb = 1'b1;
    cyc = 1'b1;
    we = write;
    adr = addr;
    datIn = wdata;
    do
    begin
      @(negedge clk);
      waitCycles++;
    end
    while (!ack && waitCycles < 8);
    checkValue("ack_o delay", 32'(waitCycles), 32'd1);
    rdata = datOut;
    stb = 1'b0;
    cyc = 1'b0;
    we = 1'b0;
  endtask

  task automatic writeHalf(input logic [7:0] idx, input logic half, input logic [15:0] data);
    logic [15:0] rd;
    wbAccess(1'b1, {1'b0, idx, half}, data, rd);
    if (half)
      tableWords[idx][31:16] = data;
    else
      tableWords[idx][15:0] = data;
  endtask

  task automatic writeDesc(input logic [7:0] idx, input descWord_t d);
    writeHalf(idx, 1'b0, d[15:0]);
    writeHalf(idx, 1'b1, d[31:16]);
  endtask

  task automatic readStatus(output logic [15:0] status);
    wbAccess(1'b0, CtrlAddr, 16'h0000, status);
  endtask

  task automatic startRun();
    logic [15:0] rd;
    wbAccess(1'b1, CtrlAddr, 16'h0001, rd);
  endtask

  task automatic waitIdle(output logic [15:0] status);
    do
      readStatus(status);
    while (status[0]);
    repeat (4) @(negedge clk);
  endtask

  // ------------------------------
  // Run checking
  // ------------------------------
  task automatic compareRun(input int streamBase, input int pktBase, input logic [15:0] status);
    int         gotLen;
    logic [9:0] g;
    logic [9:0] e;
    gotLen = gotStream.size() - streamBase;
    checkValue("byte count", 32'(gotLen), 32'(expStream.size()));
    for (int j = 0; j < expStream.size() && j < gotLen; j++)
    begin
      g = gotStream[streamBase + j];
      e = expStream[j];
      checkValue("txData_o", 32'(g[7:0]), 32'(e[7:0]));
      checkValue("txSop_o", 32'(g[9]), 32'(e[9]));
      checkValue("txEop_o", 32'(g[8]), 32'(e[8]));
    end
    checkValue("packet count", 32'(gotPkts - pktBase), 32'(expPkts));
    checkValue("status count", 32'(status[15:8]), 32'(expPkts[7:0]));
  endtask

  task automatic runAndCheck(input int descs);
    logic [15:0] status;
    int          streamBase;
    int          pktBase;
    buildExpected();
    addBudget(2, descs, expStream.size());
    streamBase = gotStream.size();
    pktBase = gotPkts;
    startRun();
    readStatus(status);
    checkValue("status busy", 32'(status[0]), 32'd1);
    waitIdle(status);
    compareRun(streamBase, pktBase, status);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic testRegisterAccess();
    logic [7:0]  idx [16];
    logic        half [16];
    logic [15:0] rd;
    addBudget(32, 0, 0);
    for (int n = 0; n < 16; n++)
    begin
      idx[n] = 8'($urandom);
      half[n] = 1'($urandom);
      writeHalf(idx[n], half[n], 16'($urandom));
    end
    for (int n = 0; n < 16; n++)
    begin
      wbAccess(1'b0, {1'b0, idx[n], half[n]}, 16'h0000, rd);
      checkValue("dat_o", 32'(rd),
                 32'(half[n] ? tableWords[idx[n]][31:16] : tableWords[idx[n]][15:0]));
    end
  endtask

  task automatic testRandomRun();
    int nFill;
    nFill = int'($urandom_range(10, 6));
    addBudget(2 * (nFill + 1), 0, 0);
    for (int i = 0; i < nFill; i++)
      writeDesc(8'(i), makeFill(8'($urandom_range(32, 1)), 8'($urandom), 8'($urandom)));
    writeDesc(8'(nFill), makeEnd());
    runAndCheck(nFill + 1);
  endtask

  task automatic testSkipAndEnd();
    descWord_t d;
    addBudget(20, 0, 0);
    for (int i = 0; i < 10; i++)
    begin
      if (i == 5)
        d = makeEnd();
      else if (i < 5 && i % 2 == 0)
        d = makeFill(8'd0, 8'($urandom), 8'($urandom));
      else
        d = makeFill(8'($urandom_range(16, 1)), 8'($urandom), 8'($urandom));
      writeDesc(8'(i), d);
    end
    runAndCheck(6);
  endtask

  task automatic testStatus();
    logic [15:0] status;
    logic [15:0] rd;
    addBudget(10, 0, 0);
    // Count of the previous run stays until the next start
    readStatus(status);
    checkValue("status busy", 32'(status[0]), 32'd0);
    checkValue("status count", 32'(status[15:8]), 32'(expPkts[7:0]));
    // Other control words read as zero while the count is nonzero
    wbAccess(1'b0, CtrlAddr + 10'd1, 16'h0000, rd);
    checkValue("dat_o ctrl+1", 32'(rd), 32'd0);
    for (int i = 0; i < 3; i++)
      writeDesc(8'(i), makeFill(8'($urandom_range(24, 1)), 8'($urandom), 8'($urandom)));
    writeDesc(8'd3, makeEnd());
    runAndCheck(4);
  endtask

  task automatic testStartWhileBusy();
    logic [15:0] status;
    int          streamBase;
    int          pktBase;
    writeDesc(8'd0, makeFill(8'd4, 8'($urandom), 8'($urandom)));
    writeDesc(8'd1, makeFill(8'd200, 8'($urandom), 8'($urandom)));
    writeDesc(8'd2, makeFill(8'($urandom_range(16, 1)), 8'($urandom), 8'($urandom)));
    writeDesc(8'd3, makeEnd());
    buildExpected();
    addBudget(12, 4, expStream.size());
    streamBase = gotStream.size();
    pktBase = gotPkts;
    startRun();
    // Second start lands during the long packet
    do
      readStatus(status);
    while (status[15:8] == 8'd0);
    checkValue("status busy", 32'(status[0]), 32'd1);
    startRun();
    waitIdle(status);
    compareRun(streamBase, pktBase, status);
  endtask

  task automatic testFullTable();
    addBudget(2 * NumDesc, 0, 0);
    for (int i = 0; i < NumDesc; i++)
      writeDesc(8'(i), makeFill(8'($urandom_range(6, 0)), 8'($urandom), 8'($urandom)));
    runAndCheck(NumDesc);
  endtask

  initial
  begin
    void'($urandom(32'h1701));
    rstN = 1'b0;
    stb = 1'b0;
    cyc = 1'b0;
    we = 1'b0;
    adr = '0;
    datIn = '0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    checkValue("ack_o", 32'(ack), 32'd0);
    checkValue("txValid_o", 32'(txValid), 32'd0);

    testRegisterAccess();
    finishTest("register access");
    testRandomRun();
    finishTest("random run");
    testSkipAndEnd();
    finishTest("skip and end");
    testStatus();
    finishTest("status");
    testStartWhileBusy();
    finishTest("start while busy");
    testFullTable();
    finishTest("full table");

    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: pktGen.f
+incdir+testbench
source/pktGenPkg.sv
source/wbHostPort.sv
source/descMemory.sv
source/pktSequencer.sv
source/txFramer.sv
source/pktGenTop.sv
testbench/pktGenTb.sv

// File: runSim.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module pktGenTb -f pktGen.f -o pktGenSim \
  && ./obj_dir/pktGenSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
